// File: hdl/stream_pkg.sv
// Data-path definitions for the stream engine, referenced by scoped name from RTL and testbench
`default_nettype none

package stream_pkg;

  // Beat payload width
  localparam int DATA_W = 16;

  // FIFO depth chosen at the top level
  localparam int FIFO_DEPTH = 16;

  // One stream beat with its end-of-packet flag
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } beat_t;

endpackage

`default_nettype wire

// File: hdl/cfg_pkg.sv
// Configuration definitions for the stream engine: opcodes, register map and op config struct
`default_nettype none

package cfg_pkg;

  localparam int CFG_ADDR_W = 2;

  // Operations applied to each beat's data
  typedef enum logic [1:0] {
    OP_PASS = 2'd0,
    OP_ADD  = 2'd1,
    OP_SUB  = 2'd2,
    OP_XOR  = 2'd3
  } opcode_t;

  // Register map of the configuration port
  typedef enum logic [CFG_ADDR_W-1:0] {
    REG_OPCODE  = 2'd0,
    REG_OPERAND = 2'd1,
    REG_COUNT   = 2'd2,
    REG_STATUS  = 2'd3
  } reg_addr_t;

  // Settings driven from the register block to the operation unit
  typedef struct packed {
    opcode_t                     opcode;
    logic [stream_pkg::DATA_W-1:0] operand;
  } op_cfg_t;

endpackage

`default_nettype wire

// File: hdl/simple_dual_port_ram.sv
// Beat storage with one write port and one registered read port, used behind the FIFO
`timescale 1ns/1ns
`default_nettype none

module simple_dual_port_ram #(
  parameter int DEPTH = 16
) (
  input  logic                  clk,
  input  logic                  wr_en,
  input  logic [ADDR_W-1:0]     wr_addr,
  input  stream_pkg::beat_t     wr_din,
  input  logic [ADDR_W-1:0]     rd_addr,
  output stream_pkg::beat_t     rd_dout
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  stream_pkg::beat_t mem [DEPTH];

  // Read data shows up one cycle after the address
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_din;
    end
    rd_dout <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: hdl/fifo.sv
// Full-throughput streaming FIFO with registered output, hides the one-cycle RAM read latency
`timescale 1ns/1ns
`default_nettype none

module fifo #(
  parameter int DEPTH = 16
) (
  input  logic              clk,
  input  logic              rst,

  input  stream_pkg::beat_t in_beat,
  input  logic              in_valid,
  output logic              in_ready,

  output stream_pkg::beat_t out_beat,
  output logic              out_valid,
  input  logic              out_ready,

  output logic              empty
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);

  // RAM side state
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              rd_valid;
  stream_pkg::beat_t ram_dout;

  // Two output registers, rd_sel points at the one presented
  stream_pkg::beat_t reg_beat [2];
  logic [1:0]        reg_valid;
  logic              rd_sel;
  logic              wr_sel;

  logic              push;
  logic              pop_ram;
  logic              drain;
  logic [2:0]        pending;

  assign in_ready = (count != CNT_W'(DEPTH));
  assign push     = in_valid && in_ready;
  assign drain    = out_valid && out_ready;

  // Beats held in the registers after this edge, counting the read in flight
  assign pending = 3'(reg_valid[0]) + 3'(reg_valid[1]) + 3'(rd_valid) - 3'(drain);

  // A new read lands next edge, so leave room for it even if nothing drains
  assign pop_ram = (count != '0) && (pending <= 3'd1);

  // Fill the presented register first, else the other one
  assign wr_sel = rd_sel ^ reg_valid[rd_sel];

  assign out_beat  = reg_beat[rd_sel];
  assign out_valid = reg_valid[rd_sel];
  assign empty     = (count == '0) && !rd_valid && (reg_valid == 2'b00);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      rd_valid  <= 1'b0;
      reg_valid <= 2'b00;
      rd_sel    <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ram) begin
        rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end

      case ({push, pop_ram})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // One-cycle pulse marking valid RAM read data
      rd_valid <= pop_ram;

      if (drain) begin
        reg_valid[rd_sel] <= 1'b0;
        rd_sel            <= ~rd_sel;
      end
      // wr_sel differs from a draining rd_sel, so no clash here
      if (rd_valid) begin
        reg_valid[wr_sel] <= 1'b1;
      end
    end
  end

  // Payload capture
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      reg_beat[wr_sel] <= ram_dout;
    end
  end

  simple_dual_port_ram #(
    .DEPTH (DEPTH)
  ) u_ram (
    .clk     (clk),
    .wr_en   (push),
    .wr_addr (wr_ptr),
    .wr_din  (in_beat),
    .rd_addr (rd_ptr),
    .rd_dout (ram_dout)
  );

endmodule

`default_nettype wire

// File: hdl/stream_op_unit.sv
// Registered operation stage that applies the configured opcode and operand to every beat
`timescale 1ns/1ns
`default_nettype none

module stream_op_unit (
  input  logic              clk,
  input  logic              rst,

  input  cfg_pkg::op_cfg_t  op_cfg,

  input  stream_pkg::beat_t in_beat,
  input  logic              in_valid,
  output logic              in_ready,

  output stream_pkg::beat_t out_beat,
  output logic              out_valid,
  input  logic              out_ready
);

  stream_pkg::beat_t result;
  logic              accept;

  // Room when empty or being emptied this cycle
  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  always_comb begin
    result.last = in_beat.last;
    result.data = in_beat.data;
    case (op_cfg.opcode)
      cfg_pkg::OP_ADD: result.data = in_beat.data + op_cfg.operand;
      cfg_pkg::OP_SUB: result.data = in_beat.data - op_cfg.operand;
      cfg_pkg::OP_XOR: result.data = in_beat.data ^ op_cfg.operand;
      cfg_pkg::OP_PASS: result.data = in_beat.data;
      default: result.data = in_beat.data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      // Drained with nothing behind it
      out_valid <= 1'b0;
    end
  end

  // Output payload register
  always_ff @(posedge clk) begin
    if (accept) begin
      out_beat <= result;
    end
  end

endmodule

`default_nettype wire

// File: hdl/op_config_regs.sv
// Configuration registers: opcode and operand for the op unit, delivered-beat count and status
`timescale 1ns/1ns
`default_nettype none

module op_config_regs (
  input  logic                          clk,
  input  logic                          rst,

  input  logic                          cfg_we,
  input  cfg_pkg::reg_addr_t            cfg_addr,
  input  logic [stream_pkg::DATA_W-1:0] cfg_wdata,
  output logic [stream_pkg::DATA_W-1:0] cfg_rdata,

  output cfg_pkg::op_cfg_t              op_cfg,

  input  logic                          out_valid,
  input  logic                          out_ready,
  input  logic                          fifo_empty
);

  logic [stream_pkg::DATA_W-1:0] beat_count;

  always_ff @(posedge clk) begin
    if (rst) begin
      op_cfg.opcode  <= cfg_pkg::OP_PASS;
      op_cfg.operand <= '0;
      beat_count     <= '0;
    end else begin
      if (cfg_we) begin
        case (cfg_addr)
          cfg_pkg::REG_OPCODE:  op_cfg.opcode  <= cfg_pkg::opcode_t'(cfg_wdata[1:0]);
          cfg_pkg::REG_OPERAND: op_cfg.operand <= cfg_wdata;
          // Count and status are read-only
          default: ;
        endcase
      end
      // Wraps at 2^16
      if (out_valid && out_ready) begin
        beat_count <= beat_count + 1'b1;
      end
    end
  end

  // Read mux, same cycle as the address
  always_comb begin
    case (cfg_addr)
      cfg_pkg::REG_OPCODE:  cfg_rdata = {{(stream_pkg::DATA_W - 2){1'b0}}, op_cfg.opcode};
      cfg_pkg::REG_OPERAND: cfg_rdata = op_cfg.operand;
      cfg_pkg::REG_COUNT:   cfg_rdata = beat_count;
      cfg_pkg::REG_STATUS:  cfg_rdata = {{(stream_pkg::DATA_W - 1){1'b0}}, fifo_empty};
      default:              cfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/stream_engine_top.sv
// Stream engine top level: input FIFO, operation unit and configuration registers
`timescale 1ns/1ns
`default_nettype none

module stream_engine_top (
  input  logic                          clk,
  input  logic                          rst,

  input  stream_pkg::beat_t             in_beat,
  input  logic                          in_valid,
  output logic                          in_ready,

  output stream_pkg::beat_t             out_beat,
  output logic                          out_valid,
  input  logic                          out_ready,

  input  logic                          cfg_we,
  input  cfg_pkg::reg_addr_t            cfg_addr,
  input  logic [stream_pkg::DATA_W-1:0] cfg_wdata,
  output logic [stream_pkg::DATA_W-1:0] cfg_rdata
);

  // FIFO to op unit stream
  stream_pkg::beat_t fifo_beat;
  logic              fifo_valid;
  logic              fifo_ready;
  logic              fifo_empty;

  cfg_pkg::op_cfg_t  op_cfg;

  fifo #(
    .DEPTH (stream_pkg::FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (fifo_beat),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready),
    .empty     (fifo_empty)
  );

  stream_op_unit u_op (
    .clk       (clk),
    .rst       (rst),
    .op_cfg    (op_cfg),
    .in_beat   (fifo_beat),
    .in_valid  (fifo_valid),
    .in_ready  (fifo_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  op_config_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .op_cfg     (op_cfg),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .fifo_empty (fifo_empty)
  );

endmodule

`default_nettype wire

// File: dv/stream_engine_sva.sv
// Handshake assertions for the stream engine, bound into the top level
`timescale 1ns/1ns
`default_nettype none

module stream_engine_sva (
  input logic              clk,
  input logic              rst,
  input stream_pkg::beat_t in_beat,
  input logic              in_valid,
  input logic              in_ready,
  input stream_pkg::beat_t out_beat,
  input logic              out_valid,
  input logic              out_ready
);

  // Stalled input beat held by the source
  in_hold: assert property (@(posedge clk) disable iff (rst)
    in_valid && !in_ready |=> in_valid && $stable(in_beat))
    else $error("Input beat changed or dropped while stalled");

  // Stalled output beat held by the op unit
  out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("Output beat changed or dropped while stalled");

  out_quiet_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high during reset");

endmodule

bind stream_engine_top stream_engine_sva u_sva (
  .clk       (clk),
  .rst       (rst),
  .in_beat   (in_beat),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .out_beat  (out_beat),
  .out_valid (out_valid),
  .out_ready (out_ready)
);

`default_nettype wire

// File: dv/stream_engine_tb.sv
// Testbench for the stream engine, drives both streams and the register port and checks every beat
`timescale 1ns/1ns
`default_nettype none

module stream_engine_tb;

  localparam int TOTAL_BEATS    = 64 + 3 * 32 + 200;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 20 + 500;

  // A sent beat with the configuration it will meet in the op unit
  typedef struct packed {
    cfg_pkg::opcode_t              opcode;
    logic [stream_pkg::DATA_W-1:0] operand;
    stream_pkg::beat_t             beat;
  } sent_t;

  logic                          clk = 1'b0;
  logic                          rst = 1'b1;
  stream_pkg::beat_t             in_beat;
  logic                          in_valid;
  logic                          in_ready;
  stream_pkg::beat_t             out_beat;
  logic                          out_valid;
  logic                          out_ready;
  logic                          cfg_we;
  cfg_pkg::reg_addr_t            cfg_addr;
  logic [stream_pkg::DATA_W-1:0] cfg_wdata;
  logic [stream_pkg::DATA_W-1:0] cfg_rdata;

  integer                        seed = 8995;
  int                            pass_count = 0;
  int                            fail_count = 0;
  int                            sent_total = 0;
  sent_t                         exp_q[$];
  sent_t                         mon_entry;
  cfg_pkg::opcode_t              cur_opcode = cfg_pkg::OP_PASS;
  logic [stream_pkg::DATA_W-1:0] cur_operand = '0;

  stream_engine_top UUT (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata)
  );

  always #4 clk = ~clk;

  // Expected beat from the opcode rules, data wraps at 16 bits
  function automatic stream_pkg::beat_t compute_beat(input cfg_pkg::opcode_t opcode,
                                                     input logic [15:0] operand,
                                                     input stream_pkg::beat_t beat);
    stream_pkg::beat_t res;
    res = beat;
    case (opcode)
      cfg_pkg::OP_ADD: res.data = beat.data + operand;
      cfg_pkg::OP_SUB: res.data = beat.data - operand;
      cfg_pkg::OP_XOR: res.data = beat.data ^ operand;
      default:         res.data = beat.data;
    endcase
    return res;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) begin
      pass_count++;
    end else begin
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      fail_count++;
    end
  endtask

  task automatic write_reg(input cfg_pkg::reg_addr_t addr, input logic [15:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
  endtask

  // Read data is combinational, sampled mid-cycle
  task automatic read_reg(input cfg_pkg::reg_addr_t addr, output logic [15:0] data);
    cfg_addr = addr;
    @(negedge clk);
    data = cfg_rdata;
    @(posedge clk);
    #1;
  endtask

  task automatic set_op(input cfg_pkg::opcode_t opcode, input logic [15:0] operand);
    write_reg(cfg_pkg::REG_OPCODE, {14'd0, opcode});
    write_reg(cfg_pkg::REG_OPERAND, operand);
    cur_opcode  = opcode;
    cur_operand = operand;
  endtask

  // Sends n beats and returns once all of them have left the engine
  task automatic run_traffic(input int n, input bit rand_valid, input bit rand_ready);
    int    sent;
    bit    taken;
    sent_t entry;
    sent  = 0;
    taken = 1'b0;
    while (sent < n || exp_q.size() != 0) begin
      // A stalled beat stays on the bus
      if (!in_valid || taken) begin
        in_valid = 1'b0;
        if (sent < n && (rand_valid ? 1'($random(seed)) : 1'b1)) begin
          in_beat.data = 16'($random(seed));
          in_beat.last = 1'($random(seed));
          in_valid     = 1'b1;
        end
      end
      out_ready = rand_ready ? 1'($random(seed)) : 1'b1;
      @(negedge clk);
      taken = in_valid && in_ready;
      if (taken) begin
        entry.opcode  = cur_opcode;
        entry.operand = cur_operand;
        entry.beat    = in_beat;
        exp_q.push_back(entry);
        sent++;
      end
      @(posedge clk);
      #1;
    end
    in_valid   = 1'b0;
    sent_total = sent_total + n;
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("Test %s: %s", name, (fail_count == fails_before) ? "ok" : "errors seen");
  endtask

  // Scoreboard on the output stream
  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      assert (exp_q.size() != 0) else begin
        $display("Output beat at %0t ns arrived with no beat left to expect", $time);
        fail_count++;
      end
      if (exp_q.size() != 0) begin
        mon_entry = exp_q.pop_front();
        check_value("output beat", 32'(out_beat),
                    32'(compute_beat(mon_entry.opcode, mon_entry.operand, mon_entry.beat)));
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    logic [15:0]      rd;
    int               fails;
    cfg_pkg::opcode_t ops [3];
    in_beat   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = cfg_pkg::REG_OPCODE;
    cfg_wdata = '0;
    ops[0]    = cfg_pkg::OP_ADD;
    ops[1]    = cfg_pkg::OP_SUB;
    ops[2]    = cfg_pkg::OP_XOR;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    fails = fail_count;
    check_value("in_ready after reset", 32'(in_ready), 32'd1);
    read_reg(cfg_pkg::REG_OPCODE, rd);
    check_value("REG_OPCODE after reset", 32'(rd), 32'(cfg_pkg::OP_PASS));
    read_reg(cfg_pkg::REG_OPERAND, rd);
    check_value("REG_OPERAND after reset", 32'(rd), 32'd0);
    read_reg(cfg_pkg::REG_COUNT, rd);
    check_value("REG_COUNT after reset", 32'(rd), 32'd0);
    read_reg(cfg_pkg::REG_STATUS, rd);
    check_value("REG_STATUS empty after reset", 32'(rd[0]), 32'd1);
    write_reg(cfg_pkg::REG_OPCODE, 16'h0003);
    read_reg(cfg_pkg::REG_OPCODE, rd);
    check_value("REG_OPCODE readback", 32'(rd), 32'h3);
    write_reg(cfg_pkg::REG_OPERAND, 16'hA5C3);
    read_reg(cfg_pkg::REG_OPERAND, rd);
    check_value("REG_OPERAND readback", 32'(rd), 32'hA5C3);
    write_reg(cfg_pkg::REG_COUNT, 16'h1234);
    read_reg(cfg_pkg::REG_COUNT, rd);
    check_value("REG_COUNT after write", 32'(rd), 32'd0);
    report_test("register access", fails);

    // Nonzero operand so a pass-through that applies it shows up
    fails = fail_count;
    set_op(cfg_pkg::OP_PASS, 16'($random(seed)));
    run_traffic(64, 1'b0, 1'b0);
    report_test("pass-through", fails);

    fails = fail_count;
    for (int i = 0; i < 3; i++) begin
      set_op(ops[i], 16'($random(seed)));
      run_traffic(32, 1'b0, 1'b0);
    end
    report_test("add, sub and xor", fails);

    fails = fail_count;
    set_op(cfg_pkg::OP_ADD, 16'($random(seed)));
    run_traffic(200, 1'b1, 1'b1);
    report_test("random valid and ready", fails);

    fails = fail_count;
    read_reg(cfg_pkg::REG_COUNT, rd);
    check_value("REG_COUNT after traffic", 32'(rd), 32'(16'(sent_total)));
    read_reg(cfg_pkg::REG_STATUS, rd);
    check_value("REG_STATUS empty after traffic", 32'(rd[0]), 32'd1);
    report_test("count and status", fails);

    $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hdl/stream_pkg.sv
hdl/cfg_pkg.sv
hdl/simple_dual_port_ram.sv
hdl/fifo.sv
hdl/stream_op_unit.sv
hdl/op_config_regs.sv
hdl/stream_engine_top.sv
dv/stream_engine_sva.sv
dv/stream_engine_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := stream_engine_tb
FILELIST := filelist.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
